/* Bender.yml */
package:
  name: vga_ctrl

sources:
  - vga_pkg.sv
  - vga_regs.sv
  - vga_timing.sv
  - vga_tile_mem.sv
  - vga_pixel_out.sv
  - vga_top.sv
  - target: test
    files:
      - vga_timing_assert.sv
      - tb_vga_top.sv

/* src.f */
vga_pkg.sv
vga_regs.sv
vga_timing.sv
vga_tile_mem.sv
vga_pixel_out.sv
vga_top.sv
vga_timing_assert.sv
tb_vga_top.sv

/* tb_vga_top.sv */
module tb_vga_top
    import vga_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 3;
    localparam int H_ACT     = 16;
    localparam int H_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 2;
    localparam int V_ACT     = 8;
    localparam int V_FRONT   = 1;
    localparam int TILE_BITS = 2;

    localparam int H_TOTAL    = H_SYNC + H_BACK + H_ACT + H_FRONT;
    localparam int V_TOTAL    = V_SYNC + V_BACK + V_ACT + V_FRONT;
    localparam int H_START    = H_SYNC + H_BACK;
    localparam int V_START    = V_SYNC + V_BACK;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int TILE       = 1 << TILE_BITS;
    localparam int TILE_WORDS = TILE * TILE;
    localparam int TILE_W     = 2 * TILE_BITS;

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_FRAMES  = 12;
    localparam int BUS_SLACK   = 64;
    localparam int WATCHDOG_NS = ((NUM_FRAMES + 3) * FRAME + BUS_SLACK) * CLK_PERIOD;

    logic                    vga_clk = 1'b0;
    logic                    rst_n;
    logic                    s_awvalid;
    logic                    s_awready;
    logic [AXI_ADDR_W-1:0]   s_awaddr;
    logic                    s_wvalid;
    logic                    s_wready;
    logic [AXI_DATA_W-1:0]   s_wdata;
    logic [AXI_DATA_W/8-1:0] s_wstrb;
    logic                    s_bvalid;
    logic                    s_bready;
    logic [1:0]              s_bresp;
    logic                    s_arvalid;
    logic                    s_arready;
    logic [AXI_ADDR_W-1:0]   s_araddr;
    logic                    s_rvalid;
    logic                    s_rready;
    logic [AXI_DATA_W-1:0]   s_rdata;
    logic [1:0]              s_rresp;
    logic                    h_sync;
    logic                    v_sync;
    logic [3:0]              rgb_r;
    logic [3:0]              rgb_g;
    logic [3:0]              rgb_b;

    logic        aligned     = 1'b0;
    int          pos         = 0;
    int          frames_seen = 0;
    logic [31:0] rng_state   = 32'd30;

    // register contents as seen from the bus
    logic   sw_enable = 1'b0;
    logic   sw_mode   = 1'b0;
    pixel_t sw_bg     = '0;

    // same, one and two cycles back
    logic   d1_enable = 1'b0;
    logic   d1_mode   = 1'b0;
    pixel_t d1_bg     = '0;
    logic   d2_enable = 1'b0;
    logic   d2_mode   = 1'b0;
    pixel_t d2_bg     = '0;

    // settings in force for the current frame
    logic   lat_enable = 1'b0;
    logic   lat_mode   = 1'b0;
    pixel_t lat_bg     = '0;

    pixel_t            tile_model [TILE_WORDS];
    logic              tile_pend_valid = 1'b0;
    logic [TILE_W-1:0] tile_pend_idx;
    pixel_t            tile_pend_data;
    logic              tile_pipe_valid [3];
    logic [TILE_W-1:0] tile_pipe_idx [3];
    pixel_t            tile_pipe_data [3];

    vga_top #(
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .H_ACT     (H_ACT),
        .H_FRONT   (H_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK),
        .V_ACT     (V_ACT),
        .V_FRONT   (V_FRONT),
        .TILE_BITS (TILE_BITS)
    ) i_dut (
        .vga_clk   (vga_clk),
        .rst_n     (rst_n),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_awaddr  (s_awaddr),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_bresp   (s_bresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .h_sync    (h_sync),
        .v_sync    (v_sync),
        .rgb_r     (rgb_r),
        .rgb_g     (rgb_g),
        .rgb_b     (rgb_b)
    );

    always #(CLK_PERIOD / 2) vga_clk = ~vga_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    task automatic stop_on_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic compare_pixel(input pixel_t got, input pixel_t want, input string where);
        if (got !== want) begin
            stop_on_error($sformatf("%s: rgb %03h, expected %03h", where, got, want));
        end
    endtask

    task automatic compare_sync(input logic got_h, input logic got_v, input logic want_h,
                                input logic want_v, input string where);
        if (got_h !== want_h || got_v !== want_v) begin
            stop_on_error($sformatf("%s: h_sync %b v_sync %b, expected %b %b",
                                    where, got_h, got_v, want_h, want_v));
        end
    endtask

    task automatic compare_resp(input logic [1:0] got_resp, input logic [1:0] want_resp,
                                input logic [AXI_DATA_W-1:0] got_data,
                                input logic [AXI_DATA_W-1:0] want_data, input string where);
        if (got_resp !== want_resp || got_data !== want_data) begin
            stop_on_error($sformatf("%s: resp %b data %08h, expected %b %08h",
                                    where, got_resp, got_data, want_resp, want_data));
        end
    endtask

    task automatic advance_cycle();
        @(posedge vga_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic idle_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target) begin
            advance_cycle();
        end
    endtask

    task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [1:0]        want_resp;
        logic              is_tile;
        logic [TILE_W-1:0] idx;
        int                hold;
        is_tile = (addr >= TILE_BASE) && (addr[1:0] == 2'b00)
                  && (int'(addr - TILE_BASE) < TILE_WORDS * 4);
        idx = TILE_W'((addr - TILE_BASE) >> 2);
        want_resp = (addr == REG_CTRL || addr == REG_BG || is_tile) ? RESP_OKAY : RESP_SLVERR;
        hold = rand_below(6);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = '1;
        s_wvalid  = 1'b1;
        @(negedge vga_clk);
        while (!(s_awready && s_wready)) begin
            @(negedge vga_clk);
        end
        advance_cycle();
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        // the write lands at the edge just passed
        if (addr == REG_CTRL) begin
            sw_enable = data[0];
            sw_mode   = data[1];
        end else if (addr == REG_BG) begin
            sw_bg = data[11:0];
        end else if (is_tile) begin
            tile_pend_valid = 1'b1;
            tile_pend_idx   = idx;
            tile_pend_data  = data[11:0];
        end
        repeat (hold) begin
            @(negedge vga_clk);
            if (!s_bvalid) begin
                stop_on_error("write response dropped before bready");
            end
            advance_cycle();
        end
        s_bready = 1'b1;
        @(negedge vga_clk);
        if (!s_bvalid) begin
            stop_on_error("no write response while bready is high");
        end
        compare_resp(s_bresp, want_resp, '0, '0, $sformatf("write to %03h", addr));
        advance_cycle();
        s_bready = 1'b0;
    endtask

    task automatic bus_read(input logic [AXI_ADDR_W-1:0] addr);
        logic [1:0]            want_resp;
        logic [AXI_DATA_W-1:0] want_data;
        int                    hold;
        want_resp = RESP_OKAY;
        want_data = '0;
        if (addr == REG_CTRL) begin
            want_data[0] = sw_enable;
            want_data[1] = sw_mode;
        end else if (addr == REG_BG) begin
            want_data[11:0] = sw_bg;
        end else begin
            want_resp = RESP_SLVERR;
        end
        hold = rand_below(6);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        @(negedge vga_clk);
        while (!s_arready) begin
            @(negedge vga_clk);
        end
        advance_cycle();
        s_arvalid = 1'b0;
        repeat (hold) begin
            @(negedge vga_clk);
            if (!s_rvalid) begin
                stop_on_error("read response dropped before rready");
            end
            advance_cycle();
        end
        s_rready = 1'b1;
        @(negedge vga_clk);
        if (!s_rvalid) begin
            stop_on_error("no read response while rready is high");
        end
        compare_resp(s_rresp, want_resp, s_rdata, want_data, $sformatf("read of %03h", addr));
        advance_cycle();
        s_rready = 1'b0;
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    // screen model, sampled mid-cycle
    always @(negedge vga_clk) begin : monitor
        int     h;
        int     v;
        int     x;
        int     y;
        logic   act;
        pixel_t want_rgb;
        pixel_t got_rgb;
        if (rst_n) begin
            if (i_dut.i_timing.i_timing_assert.failures != 0) begin
                stop_on_error("a timing assertion in vga_timing failed");
            end
            // tile writes show up three cycles after the handshake edge
            if (tile_pipe_valid[2]) begin
                tile_model[tile_pipe_idx[2]] = tile_pipe_data[2];
            end
            for (int i = 2; i > 0; i--) begin
                tile_pipe_valid[i] = tile_pipe_valid[i-1];
                tile_pipe_idx[i]   = tile_pipe_idx[i-1];
                tile_pipe_data[i]  = tile_pipe_data[i-1];
            end
            tile_pipe_valid[0] = tile_pend_valid;
            tile_pipe_idx[0]   = tile_pend_idx;
            tile_pipe_data[0]  = tile_pend_data;
            tile_pend_valid    = 1'b0;

            got_rgb = {rgb_r, rgb_g, rgb_b};
            if (!aligned && !h_sync && !v_sync) begin
                aligned = 1'b1;
                pos     = 0;
            end
            if (!aligned) begin
                compare_sync(h_sync, v_sync, 1'b1, 1'b1, "before first frame");
                compare_pixel(got_rgb, '0, "before first frame");
            end else begin
                h = pos % H_TOTAL;
                v = pos / H_TOTAL;
                compare_sync(h_sync, v_sync, h >= H_SYNC, v >= V_SYNC,
                             $sformatf("h=%0d v=%0d", h, v));
                if (pos == 0) begin
                    lat_enable = d2_enable;
                    lat_mode   = d2_mode;
                    lat_bg     = d2_bg;
                end
                act = (h >= H_START) && (h < H_START + H_ACT)
                      && (v >= V_START) && (v < V_START + V_ACT);
                x = h - H_START;
                y = v - V_START;
                if (!act || !lat_enable) begin
                    want_rgb = '0;
                end else if (!lat_mode) begin
                    want_rgb = lat_bg;
                end else begin
                    want_rgb = tile_model[(y % TILE) * TILE + (x % TILE)];
                end
                compare_pixel(got_rgb, want_rgb, $sformatf("pixel h=%0d v=%0d", h, v));
                pos++;
                if (pos == FRAME) begin
                    pos = 0;
                    frames_seen++;
                end
            end
            d2_enable = d1_enable;
            d2_mode   = d1_mode;
            d2_bg     = d1_bg;
            d1_enable = sw_enable;
            d1_mode   = sw_mode;
            d1_bg     = sw_bg;
        end
    end

    initial begin : stimulus
        int start;
        int stride;
        int idx;
        rst_n     = 1'b0;
        s_awvalid = 1'b0;
        s_awaddr  = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        s_rready  = 1'b0;
        for (int i = 0; i < 3; i++) begin
            tile_pipe_valid[i] = 1'b0;
        end
        for (int i = 0; i < TILE_WORDS; i++) begin
            tile_model[i] = '0;
        end
        repeat (3) @(posedge vga_clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        wait (aligned);
        advance_cycle();

        // reset values, then a colour that must stay hidden
        bus_read(REG_CTRL);
        bus_read(REG_BG);
        bus_write(REG_BG, next_random());
        idle_frames(1);

        // fill the tile in a scrambled order
        start  = rand_below(TILE_WORDS);
        stride = 2 * rand_below(TILE_WORDS / 2) + 1;
        for (int i = 0; i < TILE_WORDS; i++) begin
            idx = (start + i * stride) % TILE_WORDS;
            bus_write(TILE_BASE + AXI_ADDR_W'(idx * 4), next_random());
        end

        // holes in the map
        bus_write(12'h008, next_random());
        bus_write(12'h0fc, next_random());
        bus_write(TILE_BASE + AXI_ADDR_W'(TILE_WORDS * 4), next_random());
        bus_write(TILE_BASE + 12'h002, next_random());
        bus_read(12'h008);
        bus_read(TILE_BASE);

        bus_write(REG_CTRL, 32'h1);
        idle_frames(1);
        bus_write(REG_CTRL, 32'h3);
        idle_frames(1);

        while (frames_seen < NUM_FRAMES) begin
            case (rand_below(8))
                0: bus_write(REG_CTRL, next_random());
                1: bus_write(REG_BG, next_random());
                2: bus_write(TILE_BASE + AXI_ADDR_W'(rand_below(TILE_WORDS) * 4),
                             next_random());
                3: bus_read(REG_CTRL);
                4: bus_read(REG_BG);
                5: bus_write(12'h200 + AXI_ADDR_W'(rand_below(64) * 4), next_random());
                6: bus_read(12'h200 + AXI_ADDR_W'(rand_below(64) * 4));
                default: repeat (rand_below(40)) advance_cycle();
            endcase
        end

        advance_cycle();
        // an assertion may have fired after the last monitor poll
        if (i_dut.i_timing.i_timing_assert.failures != 0) begin
            stop_on_error("a timing assertion in vga_timing failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* vga_pixel_out.sv */
module vga_pixel_out
    import vga_pkg::*;
(
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic       hs_n,
    input  logic       vs_n,
    input  logic       active,
    input  logic       frame_start,
    input  logic       cfg_enable,
    input  logic       cfg_mode,
    input  pixel_t     cfg_bg,
    input  pixel_t     tile_pixel,
    output logic       h_sync,
    output logic       v_sync,
    output logic [3:0] rgb_r,
    output logic [3:0] rgb_g,
    output logic [3:0] rgb_b
);

    logic   hs_d;
    logic   vs_d;
    logic   active_d;
    logic   en_q;
    logic   mode_q;
    pixel_t bg_q;
    pixel_t colour;
    pixel_t rgb_q;

    // config shadow, one setting per frame
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q   <= 1'b0;
            mode_q <= 1'b0;
            bg_q   <= '0;
        end else if (frame_start) begin
            en_q   <= cfg_enable;
            mode_q <= cfg_mode;
            bg_q   <= cfg_bg;
        end
    end

    // match the RAM read latency
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_d     <= 1'b1;
            vs_d     <= 1'b1;
            active_d <= 1'b0;
        end else begin
            hs_d     <= hs_n;
            vs_d     <= vs_n;
            active_d <= active;
        end
    end

    always_comb begin
        if (!active_d || !en_q) begin
            colour = '0;
        end else if (!mode_q) begin
            colour = bg_q;
        end else begin
            colour = tile_pixel;
        end
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_sync <= 1'b1;
            v_sync <= 1'b1;
            rgb_q  <= '0;
        end else begin
            h_sync <= hs_d;
            v_sync <= vs_d;
            rgb_q  <= colour;
        end
    end

    assign rgb_r = rgb_q[11:8];
    assign rgb_g = rgb_q[7:4];
    assign rgb_b = rgb_q[3:0];

endmodule

/* vga_pkg.sv */
package vga_pkg;

    // counter and coordinate width
    localparam int COORD_W = 12;

    // bus widths of the register slave
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] pixel_t;

    // register map, byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL  = 12'h000;
    localparam logic [AXI_ADDR_W-1:0] REG_BG    = 12'h004;
    localparam logic [AXI_ADDR_W-1:0] TILE_BASE = 12'h100;

    // fields of REG_CTRL
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_MODE_BIT   = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* vga_regs.sv */
module vga_regs
    import vga_pkg::*;
#(
    parameter int TILE_BITS = 4
) (
    input  logic                    vga_clk,
    input  logic                    rst_n,

    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    input  logic [AXI_DATA_W-1:0]   s_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    output logic [1:0]              s_bresp,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    input  logic [AXI_ADDR_W-1:0]   s_araddr,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output logic [AXI_DATA_W-1:0]   s_rdata,
    output logic [1:0]              s_rresp,

    output logic                    cfg_enable,
    output logic                    cfg_mode,
    output pixel_t                  cfg_bg,
    output logic                    tile_we,
    output logic [2*TILE_BITS-1:0]  tile_waddr,
    output pixel_t                  tile_wdata
);

    localparam int TILE_WORDS = 1 << (2 * TILE_BITS);

    logic                  wr_ready;
    logic                  wr_fire;
    logic                  rd_ready;
    logic                  rd_fire;
    logic                  aw_ctrl;
    logic                  aw_bg;
    logic                  aw_tile;
    logic [AXI_ADDR_W-1:0] tile_off;
    logic [AXI_DATA_W-1:0] rd_data;
    logic [1:0]            rd_resp;

    assign s_awready = wr_ready;
    assign s_wready  = wr_ready;
    assign s_arready = rd_ready;

    assign wr_fire = wr_ready && s_awvalid && s_wvalid;
    assign rd_fire = rd_ready && s_arvalid;

    // write address decode
    assign tile_off = s_awaddr - TILE_BASE;
    assign aw_ctrl  = s_awaddr == REG_CTRL;
    assign aw_bg    = s_awaddr == REG_BG;
    assign aw_tile  = (s_awaddr >= TILE_BASE) && (s_awaddr[1:0] == 2'b00)
                      && (int'(tile_off >> 2) < TILE_WORDS);

    // write channel and config registers
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready   <= 1'b0;
            s_bvalid   <= 1'b0;
            s_bresp    <= RESP_OKAY;
            cfg_enable <= 1'b0;
            cfg_mode   <= 1'b0;
            cfg_bg     <= '0;
            tile_we    <= 1'b0;
        end else begin
            // one-cycle ready, blocked while a response is pending
            wr_ready <= s_awvalid && s_wvalid && !wr_ready && !s_bvalid;
            tile_we  <= 1'b0;
            if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                s_bresp  <= RESP_OKAY;
                if (aw_ctrl) begin
                    if (s_wstrb[0]) begin
                        cfg_enable <= s_wdata[CTRL_ENABLE_BIT];
                        cfg_mode   <= s_wdata[CTRL_MODE_BIT];
                    end
                end else if (aw_bg) begin
                    if (s_wstrb[0]) begin
                        cfg_bg[7:0] <= s_wdata[7:0];
                    end
                    if (s_wstrb[1]) begin
                        cfg_bg[11:8] <= s_wdata[11:8];
                    end
                end else if (aw_tile) begin
                    tile_we <= &s_wstrb[1:0];
                end else begin
                    s_bresp <= RESP_SLVERR;
                end
            end
        end
    end

    always_ff @(posedge vga_clk) begin
        if (wr_fire) begin
            tile_waddr <= tile_off[2*TILE_BITS+1:2];
            tile_wdata <= s_wdata[11:0];
        end
    end

    // read data mux
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        if (s_araddr == REG_CTRL) begin
            rd_data[CTRL_ENABLE_BIT] = cfg_enable;
            rd_data[CTRL_MODE_BIT]   = cfg_mode;
        end else if (s_araddr == REG_BG) begin
            rd_data[11:0] = cfg_bg;
        end else begin
            rd_resp = RESP_SLVERR;
        end
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
            s_rvalid <= 1'b0;
            s_rresp  <= RESP_OKAY;
        end else begin
            rd_ready <= s_arvalid && !rd_ready && !s_rvalid;
            if (s_rvalid && s_rready) begin
                s_rvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_rvalid <= 1'b1;
                s_rresp  <= rd_resp;
            end
        end
    end

    always_ff @(posedge vga_clk) begin
        if (rd_fire) begin
            s_rdata <= rd_data;
        end
    end

endmodule

/* vga_tile_mem.sv */
module vga_tile_mem
    import vga_pkg::*;
#(
    parameter int TILE_BITS = 4
) (
    input  logic                   vga_clk,
    input  logic                   tile_we,
    input  logic [2*TILE_BITS-1:0] tile_waddr,
    input  pixel_t                 tile_wdata,
    input  logic [TILE_BITS-1:0]   tx,
    input  logic [TILE_BITS-1:0]   ty,
    output pixel_t                 tile_pixel
);

    localparam int DEPTH = 1 << (2 * TILE_BITS);

    pixel_t mem [DEPTH];

    always_ff @(posedge vga_clk) begin
        if (tile_we) begin
            mem[tile_waddr] <= tile_wdata;
        end
    end

    // row-major, row from ty
    always_ff @(posedge vga_clk) begin
        tile_pixel <= mem[{ty, tx}];
    end

endmodule

/* vga_timing.sv */
module vga_timing
    import vga_pkg::*;
#(
    parameter int H_SYNC    = 120,
    parameter int H_BACK    = 64,
    parameter int H_ACT     = 800,
    parameter int H_FRONT   = 56,
    parameter int V_SYNC    = 6,
    parameter int V_BACK    = 23,
    parameter int V_ACT     = 600,
    parameter int V_FRONT   = 37,
    parameter int TILE_BITS = 4
) (
    input  logic                 vga_clk,
    input  logic                 rst_n,
    output logic                 hs_n,
    output logic                 vs_n,
    output logic                 active,
    output logic                 frame_start,
    output logic [TILE_BITS-1:0] tx,
    output logic [TILE_BITS-1:0] ty
);

    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACT + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACT + V_FRONT;
    localparam int H_START = H_SYNC + H_BACK;
    localparam int V_START = V_SYNC + V_BACK;

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               h_wrap;
    logic               v_wrap;
    logic               h_act;
    logic               v_act;

    assign h_wrap = h_cnt == COORD_W'(H_TOTAL - 1);
    assign v_wrap = v_cnt == COORD_W'(V_TOTAL - 1);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // line counter steps once per line
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // active window is half open at the far end
    assign h_act = (h_cnt >= COORD_W'(H_START)) && (h_cnt < COORD_W'(H_START + H_ACT));
    assign v_act = (v_cnt >= COORD_W'(V_START)) && (v_cnt < COORD_W'(V_START + V_ACT));

    assign x = h_cnt - COORD_W'(H_START);
    assign y = v_cnt - COORD_W'(V_START);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_n        <= 1'b1;
            vs_n        <= 1'b1;
            active      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hs_n        <= !(h_cnt < COORD_W'(H_SYNC));
            vs_n        <= !(v_cnt < COORD_W'(V_SYNC));
            active      <= h_act && v_act;
            frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

    // only the low bits index the tile
    always_ff @(posedge vga_clk) begin
        tx <= x[TILE_BITS-1:0];
        ty <= y[TILE_BITS-1:0];
    end

endmodule

/* vga_timing_assert.sv */
module vga_timing_assert #(
    parameter int H_SYNC = 120
) (
    input logic vga_clk,
    input logic rst_n,
    input logic hs_n,
    input logic vs_n,
    input logic active,
    input logic frame_start
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far, polled by the testbench monitor
    int unsigned failures = 0;

    // no video during either sync pulse
    no_active_in_sync: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        !(active && (!hs_n || !vs_n))
    ) else begin
        failures++;
        $error("active high while a sync pulse is low");
    end

    hsync_width: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        $fell(hs_n) |-> !hs_n [*H_SYNC] ##1 hs_n
    ) else begin
        failures++;
        $error("hs_n low pulse is not H_SYNC cycles long");
    end

    // frame start is the first pixel of line zero
    frame_start_in_sync: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        frame_start |-> (!hs_n && !vs_n)
    ) else begin
        failures++;
        $error("frame_start outside the combined sync pulses");
    end

endmodule

bind vga_timing vga_timing_assert #(
    .H_SYNC (H_SYNC)
) i_timing_assert (
    .vga_clk     (vga_clk),
    .rst_n       (rst_n),
    .hs_n        (hs_n),
    .vs_n        (vs_n),
    .active      (active),
    .frame_start (frame_start)
);

/* vga_top.sv */
module vga_top
    import vga_pkg::*;
#(
    parameter int H_SYNC    = 120,
    parameter int H_BACK    = 64,
    parameter int H_ACT     = 800,
    parameter int H_FRONT   = 56,
    parameter int V_SYNC    = 6,
    parameter int V_BACK    = 23,
    parameter int V_ACT     = 600,
    parameter int V_FRONT   = 37,
    parameter int TILE_BITS = 4
) (
    input  logic                    vga_clk,
    input  logic                    rst_n,

    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    input  logic [AXI_DATA_W-1:0]   s_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    output logic [1:0]              s_bresp,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    input  logic [AXI_ADDR_W-1:0]   s_araddr,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output logic [AXI_DATA_W-1:0]   s_rdata,
    output logic [1:0]              s_rresp,

    output logic                    h_sync,
    output logic                    v_sync,
    output logic [3:0]              rgb_r,
    output logic [3:0]              rgb_g,
    output logic [3:0]              rgb_b
);

    logic                   cfg_enable;
    logic                   cfg_mode;
    pixel_t                 cfg_bg;
    logic                   tile_we;
    logic [2*TILE_BITS-1:0] tile_waddr;
    pixel_t                 tile_wdata;
    logic                   hs_n;
    logic                   vs_n;
    logic                   active;
    logic                   frame_start;
    logic [TILE_BITS-1:0]   tx;
    logic [TILE_BITS-1:0]   ty;
    pixel_t                 tile_pixel;

    vga_regs #(
        .TILE_BITS (TILE_BITS)
    ) i_regs (
        .vga_clk    (vga_clk),
        .rst_n      (rst_n),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_awaddr   (s_awaddr),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_bresp    (s_bresp),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_araddr   (s_araddr),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .cfg_enable (cfg_enable),
        .cfg_mode   (cfg_mode),
        .cfg_bg     (cfg_bg),
        .tile_we    (tile_we),
        .tile_waddr (tile_waddr),
        .tile_wdata (tile_wdata)
    );

    vga_timing #(
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .H_ACT     (H_ACT),
        .H_FRONT   (H_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK),
        .V_ACT     (V_ACT),
        .V_FRONT   (V_FRONT),
        .TILE_BITS (TILE_BITS)
    ) i_timing (
        .vga_clk     (vga_clk),
        .rst_n       (rst_n),
        .hs_n        (hs_n),
        .vs_n        (vs_n),
        .active      (active),
        .frame_start (frame_start),
        .tx          (tx),
        .ty          (ty)
    );

    vga_tile_mem #(
        .TILE_BITS (TILE_BITS)
    ) i_tile_mem (
        .vga_clk    (vga_clk),
        .tile_we    (tile_we),
        .tile_waddr (tile_waddr),
        .tile_wdata (tile_wdata),
        .tx         (tx),
        .ty         (ty),
        .tile_pixel (tile_pixel)
    );

    // three cycles from counters to pins
    vga_pixel_out i_pixel_out (
        .vga_clk     (vga_clk),
        .rst_n       (rst_n),
        .hs_n        (hs_n),
        .vs_n        (vs_n),
        .active      (active),
        .frame_start (frame_start),
        .cfg_enable  (cfg_enable),
        .cfg_mode    (cfg_mode),
        .cfg_bg      (cfg_bg),
        .tile_pixel  (tile_pixel),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .rgb_r       (rgb_r),
        .rgb_g       (rgb_g),
        .rgb_b       (rgb_b)
    );

endmodule
